// File: verilog/quant_pkg.sv
package quant_pkg;

  // ======================================================================
  // Scalar widths
  // ======================================================================

  // Accumulator sum or per-lane bias
  typedef logic signed [31:0] acc_t;
  // Requantized output value
  typedef logic signed [7:0]  q_t;
  // Scale multiplier and right-shift amount
  typedef logic signed [15:0] mult_t;
  typedef logic        [5:0]  shift_t;

  // Output feature map geometry
  typedef logic [7:0]  dim_t;
  typedef logic [6:0]  row_t;
  typedef logic [6:0]  col_t;
  typedef logic [1:0]  blk_t;
  // Output buffer word address
  typedef logic [15:0] addr_t;

  // ======================================================================
  // Bundles
  // ======================================================================

  // Tile position, travels with every item
  typedef struct packed {
    row_t row;
    col_t col;
    blk_t blk;
  } tile_tag_t;

  // Requantization settings
  typedef struct packed {
    mult_t  mult;
    shift_t shift;
    logic   symmetric;
    q_t     zp;
  } quant_cfg_t;

  // Output geometry, blocks of 0 stands for 4
  typedef struct packed {
    dim_t out_w;
    dim_t out_h;
    blk_t blocks;
  } geom_cfg_t;

endpackage

// File: verilog/row_skew.sv
`timescale 1ns/1ps

module row_skew #(
  parameter int LANES = 16,
  parameter int DELAY = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  quant_pkg::acc_t [LANES-1:0] in_sums,
  input  quant_pkg::acc_t [LANES-1:0] in_bias,
  input  quant_pkg::tile_tag_t        in_tag,
  output logic                        out_valid,
  output quant_pkg::acc_t [LANES-1:0] out_sums,
  output quant_pkg::acc_t [LANES-1:0] out_bias,
  output quant_pkg::tile_tag_t        out_tag
);

  // Stage 0 holds the captured beat
  // Stages 1..DELAY add the skew for this row
  logic                        valid_q [DELAY+1];
  quant_pkg::acc_t [LANES-1:0] sums_q  [DELAY+1];
  quant_pkg::acc_t [LANES-1:0] bias_q  [DELAY+1];
  quant_pkg::tile_tag_t        tag_q   [DELAY+1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i <= DELAY; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i <= DELAY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload shifts every cycle
  always_ff @(posedge clk) begin
    sums_q[0] <= in_sums;
    bias_q[0] <= in_bias;
    tag_q[0]  <= in_tag;
    for (int i = 1; i <= DELAY; i++) begin
      sums_q[i] <= sums_q[i-1];
      bias_q[i] <= bias_q[i-1];
      tag_q[i]  <= tag_q[i-1];
    end
  end

  assign out_valid = valid_q[DELAY];
  assign out_sums  = sums_q[DELAY];
  assign out_bias  = bias_q[DELAY];
  assign out_tag   = tag_q[DELAY];

endmodule

// File: verilog/requant_lane.sv
`timescale 1ns/1ps

module requant_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  quant_pkg::acc_t       acc,
  input  quant_pkg::acc_t       bias,
  input  quant_pkg::quant_cfg_t qcfg,
  output quant_pkg::q_t         q
);

  // ======================================================================
  // Stage 1 bias add and scale
  // ======================================================================
  quant_pkg::acc_t    biased;
  logic signed [47:0] prod_q;

  // 32-bit wrap on the bias add
  assign biased = acc + bias;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
    end else begin
      prod_q <= 48'(biased) * 48'(qcfg.mult);
    end
  end

  // ======================================================================
  // Stage 2 round, shift, zero point, saturate
  // ======================================================================
  logic signed [63:0] rounded;
  logic signed [63:0] shifted;
  logic signed [63:0] with_zp;
  quant_pkg::q_t      sat;

  always_comb begin
    rounded = 64'(prod_q);
    // Round half up
    if (qcfg.shift != 6'd0) begin
      rounded = rounded + (64'sd1 <<< (qcfg.shift - 6'd1));
    end
    shifted = rounded >>> qcfg.shift;
    with_zp = shifted;
    if (!qcfg.symmetric) begin
      with_zp = shifted + 64'(qcfg.zp);
    end
    if (with_zp > 64'sd127) begin
      sat = 8'sd127;
    end else if (with_zp < -64'sd128) begin
      sat = -8'sd128;
    end else begin
      sat = with_zp[7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else begin
      q <= sat;
    end
  end

endmodule

// File: verilog/requant_row.sv
`timescale 1ns/1ps

module requant_row #(
  parameter int LANES = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        in_valid,
  input  quant_pkg::acc_t [LANES-1:0] in_sums,
  input  quant_pkg::acc_t [LANES-1:0] in_bias,
  input  quant_pkg::tile_tag_t        in_tag,
  input  quant_pkg::quant_cfg_t       qcfg,
  output logic                        out_valid,
  output quant_pkg::q_t [LANES-1:0]   out_q,
  output quant_pkg::tile_tag_t        out_tag
);

  // One requantizer per channel lane
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    requant_lane requant_lane_i (
      .clk   (clk),
      .rst_n (rst_n),
      .acc   (in_sums[l]),
      .bias  (in_bias[l]),
      .qcfg  (qcfg),
      .q     (out_q[l])
    );
  end

  // Valid and tag follow the two lane stages
  logic                 valid_q1;
  logic                 valid_q2;
  quant_pkg::tile_tag_t tag_q1;
  quant_pkg::tile_tag_t tag_q2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
    end else begin
      valid_q1 <= in_valid;
      valid_q2 <= valid_q1;
    end
  end

  always_ff @(posedge clk) begin
    tag_q1 <= in_tag;
    tag_q2 <= tag_q1;
  end

  assign out_valid = valid_q2;
  assign out_tag   = tag_q2;

endmodule

// File: verilog/out_addr_gen.sv
`timescale 1ns/1ps

module out_addr_gen #(
  parameter int LANES   = 16,
  parameter int ROW_OFS = 0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  quant_pkg::q_t [LANES-1:0] in_q,
  input  quant_pkg::tile_tag_t      in_tag,
  input  quant_pkg::geom_cfg_t      gcfg,
  output logic                      wr_en,
  output quant_pkg::addr_t          wr_addr,
  output quant_pkg::q_t [LANES-1:0] wr_data
);

  // ======================================================================
  // Address and bounds check
  // ======================================================================
  logic [15:0] row_abs;
  logic [2:0]  blocks_n;
  logic [31:0] addr_full;
  logic        in_range;
  logic        do_write;

  // Row this port writes for the tile
  assign row_abs = 16'(in_tag.row) + 16'(ROW_OFS);

  // Two-bit blocks field wraps 4 to 0
  assign blocks_n = (gcfg.blocks == 2'd0) ? 3'd4 : {1'b0, gcfg.blocks};

  always_comb begin
    addr_full = 32'(row_abs) * 32'(gcfg.out_w) + 32'(in_tag.col);
    addr_full = addr_full * 32'(blocks_n) + 32'(in_tag.blk);
  end

  assign in_range = (row_abs < 16'(gcfg.out_h)) &&
                    (8'(in_tag.col) < gcfg.out_w);
  assign do_write = in_valid && in_range;

  // ======================================================================
  // Write port
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en   <= 1'b0;
      wr_addr <= '0;
      wr_data <= '0;
    end else begin
      wr_en <= do_write;
      // Address and data hold between writes
      if (do_write) begin
        wr_addr <= addr_full[15:0];
        wr_data <= in_q;
      end
    end
  end

endmodule

// File: verilog/quant_stream_top.sv
`timescale 1ns/1ps

module quant_stream_top #(
  parameter int LANES = 16,
  parameter int ROWS  = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic            [ROWS-1:0]             in_valid,
  input  quant_pkg::acc_t [ROWS-1:0][LANES-1:0]  in_sums,
  input  quant_pkg::acc_t [LANES-1:0]            in_bias,
  input  quant_pkg::tile_tag_t                   in_tag,
  input  quant_pkg::quant_cfg_t                  qcfg,
  input  quant_pkg::geom_cfg_t                   gcfg,
  output logic            [ROWS-1:0]             wr_en,
  output quant_pkg::addr_t [ROWS-1:0]            wr_addr,
  output quant_pkg::q_t   [ROWS-1:0][LANES-1:0]  wr_data
);

  // ======================================================================
  // Per-row pipeline
  // ======================================================================
  // Row r is skewed by r cycles, then requantized, then written
  for (genvar r = 0; r < ROWS; r++) begin : g_row
    logic                        skew_valid;
    quant_pkg::acc_t [LANES-1:0] skew_sums;
    quant_pkg::acc_t [LANES-1:0] skew_bias;
    quant_pkg::tile_tag_t        skew_tag;

    logic                        rq_valid;
    quant_pkg::q_t [LANES-1:0]   rq_q;
    quant_pkg::tile_tag_t        rq_tag;

    row_skew #(
      .LANES (LANES),
      .DELAY (r)
    ) row_skew_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[r]),
      .in_sums   (in_sums[r]),
      .in_bias   (in_bias),
      .in_tag    (in_tag),
      .out_valid (skew_valid),
      .out_sums  (skew_sums),
      .out_bias  (skew_bias),
      .out_tag   (skew_tag)
    );

    requant_row #(
      .LANES (LANES)
    ) requant_row_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (skew_valid),
      .in_sums   (skew_sums),
      .in_bias   (skew_bias),
      .in_tag    (skew_tag),
      .qcfg      (qcfg),
      .out_valid (rq_valid),
      .out_q     (rq_q),
      .out_tag   (rq_tag)
    );

    // Own write port per row
    out_addr_gen #(
      .LANES   (LANES),
      .ROW_OFS (r)
    ) out_addr_gen_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (rq_valid),
      .in_q     (rq_q),
      .in_tag   (rq_tag),
      .gcfg     (gcfg),
      .wr_en    (wr_en[r]),
      .wr_addr  (wr_addr[r]),
      .wr_data  (wr_data[r])
    );
  end

endmodule

// File: dv/quant_ref.svh
`ifndef QUANT_REF_SVH
`define QUANT_REF_SVH

// ======================================================================
// Expected values for the requantizer
// ======================================================================

// Bias add with 32-bit wrap, scale, round half up, zero point, saturate
function automatic quant_pkg::q_t requant_value(input quant_pkg::acc_t acc,
                                                input quant_pkg::acc_t bias,
                                                input quant_pkg::quant_cfg_t cfg);
  int     biased;
  longint val;
  biased = int'(acc) + int'(bias);
  val = longint'(biased) * longint'(cfg.mult);
  if (cfg.shift != 6'd0) begin
    val = val + (longint'(1) <<< (int'(cfg.shift) - 1));
  end
  val = val >>> int'(cfg.shift);
  if (!cfg.symmetric) begin
    val = val + longint'(cfg.zp);
  end
  if (val > 127) return 8'sd127;
  if (val < -128) return -8'sd128;
  return 8'(val);
endfunction

// Word address with blocks of 0 counted as 4
function automatic quant_pkg::addr_t word_addr(input int row_abs, input quant_pkg::col_t col,
                                               input quant_pkg::blk_t blk,
                                               input quant_pkg::geom_cfg_t g);
  int nblk;
  int a;
  nblk = (g.blocks == 2'd0) ? 4 : int'(g.blocks);
  a = (row_abs * int'(g.out_w) + int'(col)) * nblk + int'(blk);
  return 16'(a);
endfunction

function automatic bit in_bounds(input int row_abs, input quant_pkg::col_t col,
                                 input quant_pkg::geom_cfg_t g);
  return (row_abs < int'(g.out_h)) && (int'(col) < int'(g.out_w));
endfunction

`endif

// File: dv/tb_quant_stream.sv
`timescale 1ns/1ps

module tb_quant_stream;

  localparam int LANES        = 4;
  localparam int ROWS         = 4;
  localparam int RESET_CYCLES = 8;
  localparam int N_CFG        = 13;
  localparam int N_BEATS      = 24;
  localparam int DRAIN        = 10;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + N_CFG * (N_BEATS + DRAIN) + 50;

  `include "quant_ref.svh"

  typedef struct packed {
    int                        due;
    quant_pkg::addr_t          addr;
    quant_pkg::q_t [LANES-1:0] data;
  } exp_t;

  logic                                  clk = 1'b0;
  logic                                  rst_n;
  logic            [ROWS-1:0]            in_valid;
  quant_pkg::acc_t [ROWS-1:0][LANES-1:0] in_sums;
  quant_pkg::acc_t [LANES-1:0]           in_bias;
  quant_pkg::tile_tag_t                  in_tag;
  quant_pkg::quant_cfg_t                 qcfg;
  quant_pkg::geom_cfg_t                  gcfg;
  logic            [ROWS-1:0]            wr_en;
  quant_pkg::addr_t [ROWS-1:0]           wr_addr;
  quant_pkg::q_t   [ROWS-1:0][LANES-1:0] wr_data;

  quant_pkg::quant_cfg_t     cur_qcfg;
  quant_pkg::geom_cfg_t      cur_gcfg;
  exp_t                      exp_q [ROWS][$];
  quant_pkg::addr_t          last_addr [ROWS];
  quant_pkg::q_t [LANES-1:0] last_data [ROWS];
  int cyc = 0;
  int value_errs = 0;
  int unexpected_errs = 0;
  int missing_errs = 0;

  quant_stream_top #(.LANES(LANES), .ROWS(ROWS)) quant_stream_top_i (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sums(in_sums), .in_bias(in_bias),
    .in_tag(in_tag), .qcfg(qcfg), .gcfg(gcfg), .wr_en(wr_en), .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: value %0d, unexpected %0d, missing %0d", value_errs,
               unexpected_errs, missing_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic quant_pkg::acc_t rand_acc(input int mag_bits);
    return quant_pkg::acc_t'(int'($urandom) >>> (32 - mag_bits));
  endfunction

  function automatic quant_pkg::tile_tag_t inrange_tag(input quant_pkg::geom_cfg_t g);
    quant_pkg::tile_tag_t t;
    int row_max;
    int col_max;
    row_max = (int'(g.out_h) - ROWS > 127) ? 127 : int'(g.out_h) - ROWS;
    col_max = (int'(g.out_w) - 1 > 127) ? 127 : int'(g.out_w) - 1;
    t.row = 7'($urandom_range(0, row_max));
    t.col = 7'($urandom_range(0, col_max));
    t.blk = 2'($urandom_range(0, (g.blocks == 2'd0) ? 3 : int'(g.blocks) - 1));
    return t;
  endfunction

  // Drives one beat and queues the expected writes per row
  task automatic drive_beat(input logic [ROWS-1:0] mask, input quant_pkg::tile_tag_t tag,
                            input int mag_bits);
    quant_pkg::acc_t [ROWS-1:0][LANES-1:0] sums;
    quant_pkg::acc_t [LANES-1:0]           bias;
    exp_t                                  e;
    int                                    drive_cyc;
    for (int l = 0; l < LANES; l++) begin
      bias[l] = rand_acc(mag_bits);
      for (int r = 0; r < ROWS; r++) sums[r][l] = rand_acc(mag_bits);
    end
    @(posedge clk);
    // Counter steps to the next value at this edge
    drive_cyc = cyc + 1;
    in_valid <= mask;
    in_sums  <= sums;
    in_bias  <= bias;
    in_tag   <= tag;
    qcfg     <= cur_qcfg;
    gcfg     <= cur_gcfg;
    for (int r = 0; r < ROWS; r++) begin
      if (mask[r] && in_bounds(int'(tag.row) + r, tag.col, cur_gcfg)) begin
        e.due  = drive_cyc + r + 4;
        e.addr = word_addr(int'(tag.row) + r, tag.col, tag.blk, cur_gcfg);
        for (int l = 0; l < LANES; l++) begin
          e.data[l] = requant_value(sums[r][l], bias[l], cur_qcfg);
        end
        exp_q[r].push_back(e);
      end
    end
  endtask

  // ======================================================================
  // Compare at the falling edge
  // ======================================================================
  always @(negedge clk) begin : compare
    exp_t e;
    for (int r = 0; r < ROWS; r++) begin
      if (exp_q[r].size() > 0 && exp_q[r][0].due == cyc) begin
        e = exp_q[r].pop_front();
        if (!wr_en[r]) begin
          missing_errs++;
          $display("Missing write on row %0d at %0t, address %h expected", r, $time, e.addr);
        end else begin
          if (wr_addr[r] != e.addr) begin
            value_errs++;
            $display("CHECK FAILED at %0t: row %0d address %h, expected %h", $time, r,
                     wr_addr[r], e.addr);
          end
          if (wr_data[r] != e.data) begin
            value_errs++;
            $display("CHECK FAILED at %0t: row %0d data %h, expected %h", $time, r,
                     wr_data[r], e.data);
          end
          last_addr[r] = wr_addr[r];
          last_data[r] = wr_data[r];
        end
      end else if (wr_en[r]) begin
        unexpected_errs++;
        $display("Unexpected write on row %0d at %0t, address %h", r, $time, wr_addr[r]);
        last_addr[r] = wr_addr[r];
        last_data[r] = wr_data[r];
      end else if (wr_addr[r] != last_addr[r] || wr_data[r] != last_data[r]) begin
        value_errs++;
        $display("CHECK FAILED at %0t: row %0d port changed while idle", $time, r);
      end
    end
  end

  initial begin : main
    quant_pkg::tile_tag_t tag;
    logic [ROWS-1:0]      mask;
    int                   mag;
    void'($urandom(6));
    rst_n = 1'b0;
    in_valid = '0;
    in_sums = '0;
    in_bias = '0;
    in_tag = '0;
    qcfg = '0;
    gcfg = '0;
    for (int r = 0; r < ROWS; r++) begin
      last_addr[r] = '0;
      last_data[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // 0 idle, 1 saturation, 2..5 random scale, 6 back-to-back, 7..9 edges, 10..12 geometry
    for (int c = 0; c < N_CFG; c++) begin
      cur_qcfg = '{mult: 16'($urandom), shift: 6'($urandom_range(1, 30)), symmetric: 1'b0,
                   zp: 8'($urandom)};
      // Symmetric mode ignores a nonzero zero point
      if (c == 1) cur_qcfg = '{mult: 16'sd1, shift: 6'd0, symmetric: 1'b1, zp: 8'sd45};
      cur_gcfg = '{out_w: 8'd16, out_h: 8'd32, blocks: 2'd2};
      if (c >= 7) begin
        cur_gcfg.out_w  = (c < 10) ? 8'($urandom_range(8, 20)) : 8'($urandom_range(1, 255));
        cur_gcfg.out_h  = (c < 10) ? 8'($urandom_range(8, 20)) : 8'd255;
        cur_gcfg.blocks = 2'($urandom_range(1, 3));
      end
      mag = (cur_qcfg.shift > 6'd10) ? int'(cur_qcfg.shift) - 8 : 2;
      for (int i = 0; i < N_BEATS; i++) begin
        tag  = inrange_tag(cur_gcfg);
        mask = ROWS'($urandom_range(1, 15));
        if (c == 0) mask = '0;
        if (c == 6) mask = '1;
        if (c == 1) mag = (i % 2 == 0) ? 31 : 8;
        if (c >= 7 && c < 10) begin
          tag.row = 7'(int'(cur_gcfg.out_h) - int'($urandom_range(0, 4)));
          tag.col = 7'(int'(cur_gcfg.out_w) - 2 + int'($urandom_range(0, 3)));
        end
        drive_beat(mask, tag, mag);
      end
      repeat (DRAIN) drive_beat('0, tag, 8);
    end

    for (int r = 0; r < ROWS; r++) begin
      if (exp_q[r].size() > 0) begin
        missing_errs += exp_q[r].size();
        $display("Missing writes: %0d still expected on row %0d", exp_q[r].size(), r);
      end
    end
    $display("Errors: value %0d, unexpected %0d, missing %0d", value_errs, unexpected_errs,
             missing_errs);
    if (value_errs + unexpected_errs + missing_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+dv
verilog/quant_pkg.sv
verilog/row_skew.sv
verilog/requant_lane.sv
verilog/requant_row.sv
verilog/out_addr_gen.sv
verilog/quant_stream_top.sv
dv/tb_quant_stream.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_quant_stream -f compile.f -o sim_quant_stream
./obj_dir/sim_quant_stream | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
